// File: DekatronCounter.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module DekatronCounter #(
    parameter int numDigits = 6
) (
    input  logic                              Clk,
    input  logic                              Rst_n,
    input  logic                              stepTick,
    input  bfPkg::ctrCmd_t                    Cmd,
    output logic                              Ready,
    output logic [numDigits*`DIGIT_WIDTH-1:0] Out,
    output logic                              Zero
);

    localparam int ptrWidth = (numDigits > 1) ? $clog2(numDigits) : 1;

    logic [numDigits-1:0][`DIGIT_WIDTH-1:0] digits;
    logic [ptrWidth-1:0]                    carryPtr;   // digit that moves on the next tick
    logic                                   busy;
    logic                                   stepDec;
    logic [`DIGIT_WIDTH-1:0]                curDigit;
    logic [`DIGIT_WIDTH-1:0]                nextDigit;
    logic                                   wrap;
    logic                                   topDigit;

    // next value of the pending digit and whether it wraps around
    always_comb begin
        curDigit = digits[carryPtr];
        if (stepDec) begin
            wrap      = (curDigit == '0);
            nextDigit = wrap ? `DIGIT_WIDTH'(9) : curDigit - 1'b1;
        end else begin
            wrap      = (curDigit >= `DIGIT_WIDTH'(9));
            nextDigit = wrap ? '0 : curDigit + 1'b1;
        end
    end

    assign topDigit = (carryPtr == ptrWidth'(numDigits - 1));

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            digits   <= '0;
            carryPtr <= '0;
            busy     <= 1'b0;
            stepDec  <= 1'b0;
        end else if (!busy) begin
            if (Cmd.request) begin
                busy     <= 1'b1;
                stepDec  <= Cmd.dec;
                carryPtr <= '0;     // always start at the units tube
            end
        end else if (stepTick) begin
            digits[carryPtr] <= nextDigit;
            if (wrap && !topDigit) begin
                carryPtr <= carryPtr + 1'b1;    // carry or borrow moves up one tube
            end else begin
                busy <= 1'b0;   // top digit wraps silently
            end
        end
    end

    assign Ready = ~busy;
    assign Out   = digits;
    assign Zero  = (digits == '0);

endmodule

// File: HsClkGen.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module HsClkGen (
    input  logic Clk,
    input  logic Rst_n,
    output logic stepTick
);

    localparam int divWidth = (`STEP_DIV > 1) ? $clog2(`STEP_DIV) : 1;

    logic [divWidth-1:0] divCount;

    // slow drive pulse for the counter tubes
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            divCount <= '0;
            stepTick <= 1'b0;
        end else begin
            if (divCount == divWidth'(`STEP_DIV - 1)) begin
                divCount <= '0;
                stepTick <= 1'b1;   // one Clk wide
            end else begin
                divCount <= divCount + 1'b1;
                stepTick <= 1'b0;
            end
        end
    end

endmodule

// File: InsnFetchTop.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module InsnFetchTop (
    input  logic          Clk,
    input  logic          Rst_n,
    input  logic          Request,
    input  logic          dataIsZeroed,
    output logic          Ready,
    output bfPkg::fetch_t Fetch
);

    import bfPkg::*;

    logic    stepTick;
    ctrCmd_t ipCmd;
    ctrCmd_t loopCmd;
    logic    ipReady;
    fetch_t  ipFetch;
    logic    loopReady;
    logic    loopZero;

    HsClkGen u_HsClkGen (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .stepTick (stepTick)
    );

    IpCounter u_IpCounter (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .stepTick (stepTick),
        .Cmd      (ipCmd),
        .Ready    (ipReady),
        .Fetch    (ipFetch)
    );

    // bracket nesting depth, only its zero state matters
    DekatronCounter #(
        .numDigits (`LOOP_DIGITS)
    ) u_LoopCounter (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .stepTick (stepTick),
        .Cmd      (loopCmd),
        .Ready    (loopReady),
        .Out      (),
        .Zero     (loopZero)
    );

    IpLine u_IpLine (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .Request      (Request),
        .dataIsZeroed (dataIsZeroed),
        .Ready        (Ready),
        .Fetch        (Fetch),
        .ipCmd        (ipCmd),
        .ipReady      (ipReady),
        .ipFetch      (ipFetch),
        .loopCmd      (loopCmd),
        .loopReady    (loopReady),
        .loopZero     (loopZero)
    );

endmodule

// File: IpCounter.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module IpCounter (
    input  logic           Clk,
    input  logic           Rst_n,
    input  logic           stepTick,
    input  bfPkg::ctrCmd_t Cmd,
    output logic           Ready,
    output bfPkg::fetch_t  Fetch
);

    import bfPkg::*;

    logic                               ctrReady;
    logic [`IP_DIGITS*`DIGIT_WIDTH-1:0] ipAddr;
    opcode_t                            romData;
    logic                               romValid;

    // instruction pointer tubes
    DekatronCounter #(
        .numDigits (`IP_DIGITS)
    ) u_IpDekatron (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .stepTick (stepTick),
        .Cmd      (Cmd),
        .Ready    (ctrReady),
        .Out      (ipAddr),
        .Zero     ()
    );

    // only the low two digits reach the program store
    ProgramRom u_ProgramRom (
        .Clk  (Clk),
        .Addr (ipAddr[2*`DIGIT_WIDTH-1:0]),
        .Data (romData)
    );

    // the ROM word trails the settled address by one cycle
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            romValid <= 1'b0;
        end else begin
            romValid <= ctrReady;
        end
    end

    assign Ready         = ctrReady & romValid;    // drops with the counter, rises a cycle late
    assign Fetch.address = ipAddr;
    assign Fetch.insn    = romData;

endmodule

// File: IpLine.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module IpLine (
    input  logic           Clk,
    input  logic           Rst_n,
    input  logic           Request,
    input  logic           dataIsZeroed,
    output logic           Ready,
    output bfPkg::fetch_t  Fetch,
    output bfPkg::ctrCmd_t ipCmd,
    input  logic           ipReady,
    input  bfPkg::fetch_t  ipFetch,
    output bfPkg::ctrCmd_t loopCmd,
    input  logic           loopReady,
    input  logic           loopZero
);

    import bfPkg::*;

    lineState_t lineState;
    logic       scanning;   // bracket lookup in progress
    logic       scanBack;   // lookup runs toward address 0
    logic       curOpen;
    logic       curClose;
    logic       startBack;
    logic       startJump;
    logic       scanOpen;
    logic       scanClose;
    logic       scanDeeper;
    logic       scanShallower;
    logic       ipDone;
    logic       loopDone;

    // brackets on the presented instruction decide the jump
    assign curOpen   = (Fetch.insn == OP_LOOP_OPEN);
    assign curClose  = (Fetch.insn == OP_LOOP_CLOSE);
    assign startBack = curClose & ~dataIsZeroed;
    assign startJump = (curOpen & dataIsZeroed) | startBack;

    // brackets met while scanning
    assign scanOpen      = (ipFetch.insn == OP_LOOP_OPEN);
    assign scanClose     = (ipFetch.insn == OP_LOOP_CLOSE);
    assign scanDeeper    = scanBack ? scanClose : scanOpen;
    assign scanShallower = scanBack ? scanOpen : scanClose;

    // a counter's Ready is stale while our strobe is still out
    assign ipDone   = ipReady & ~ipCmd.request;
    assign loopDone = loopReady & ~loopCmd.request;

    assign Ready = ~Request & ((lineState == IDLE) | (lineState == READY));

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            lineState <= IDLE;
            scanning  <= 1'b0;
            scanBack  <= 1'b0;
            ipCmd     <= '0;
            loopCmd   <= '0;
            Fetch     <= '0;    // address 000000, OP_NOP
        end else begin
            ipCmd.request   <= 1'b0;  // strobes are single cycle
            loopCmd.request <= 1'b0;

            case (lineState)
                IDLE, READY: begin
                    if (Request) begin
                        scanBack <= startBack;
                        if (startJump) begin
                            // nesting goes to one before the pointer moves
                            scanning  <= 1'b1;
                            loopCmd   <= '{request: 1'b1, dec: 1'b0};
                            lineState <= LOOP_COUNT;
                        end else begin
                            scanning  <= 1'b0;
                            ipCmd     <= '{request: 1'b1, dec: 1'b0};
                            lineState <= INSN_WAIT;
                        end
                    end else begin
                        lineState <= IDLE;
                    end
                end

                INSN_WAIT: begin
                    if (ipDone) begin
                        if (!scanning) begin
                            Fetch     <= ipFetch;
                            lineState <= READY;
                        end else if (scanDeeper | scanShallower) begin
                            loopCmd   <= '{request: 1'b1, dec: scanShallower};
                            lineState <= LOOP_COUNT;
                        end else begin
                            ipCmd <= '{request: 1'b1, dec: scanBack};  // skip plain opcode
                        end
                    end
                end

                LOOP_COUNT: begin
                    if (loopDone) begin
                        if (loopZero) begin
                            // sitting on the match, land one past it
                            scanning <= 1'b0;
                            ipCmd    <= '{request: 1'b1, dec: 1'b0};
                        end else begin
                            ipCmd <= '{request: 1'b1, dec: scanBack};
                        end
                        lineState <= INSN_WAIT;
                    end
                end

                default: lineState <= IDLE;
            endcase
        end
    end

endmodule

// File: ProgramRom.sv
`timescale 1ns/1ps
`include "ipLine_defs.svh"

module ProgramRom (
    input  logic                      Clk,
    input  logic [2*`DIGIT_WIDTH-1:0] Addr,   // tens and units, BCD
    output bfPkg::opcode_t            Data
);

    import bfPkg::*;

    localparam int idxWidth = $clog2(`ROM_DEPTH);

    logic [`INSN_WIDTH-1:0] romMem [0:`ROM_DEPTH-1];
    logic [`DIGIT_WIDTH-1:0] tens;
    logic [`DIGIT_WIDTH-1:0] units;
    logic [idxWidth-1:0]    romIndex;

    initial begin
        $readmemh("program.hex", romMem);
    end

    assign tens     = Addr[2*`DIGIT_WIDTH-1:`DIGIT_WIDTH];
    assign units    = Addr[`DIGIT_WIDTH-1:0];
    assign romIndex = idxWidth'(tens) * idxWidth'(10) + idxWidth'(units);  // BCD to binary

    always_ff @(posedge Clk) begin
        Data <= opcode_t'(romMem[romIndex]);
    end

endmodule

// File: bfPkg.sv
`include "ipLine_defs.svh"

package bfPkg;

    // program opcodes as stored in program.hex
    typedef enum logic [`INSN_WIDTH-1:0] {
        OP_NOP        = 4'd0,
        OP_INC        = 4'd1,   // +
        OP_DEC        = 4'd2,   // -
        OP_RIGHT      = 4'd3,   // >
        OP_LEFT       = 4'd4,   // <
        OP_OUT        = 4'd5,   // .
        OP_IN         = 4'd6,   // ,
        OP_LOOP_OPEN  = 4'd7,   // [
        OP_LOOP_CLOSE = 4'd8,   // ]
        OP_HALT       = 4'd9
    } opcode_t;

    // fetch sequencer, one-hot
    typedef enum logic [3:0] {
        IDLE       = 4'b0001,
        INSN_WAIT  = 4'b0010,
        LOOP_COUNT = 4'b0100,
        READY      = 4'b1000
    } lineState_t;

    // step command into a dekatron counter
    typedef struct packed {
        logic request;  // one-cycle strobe
        logic dec;      // 1 counts down
    } ctrCmd_t;

    // pointer value and the opcode read at it
    typedef struct packed {
        logic [`IP_DIGITS*`DIGIT_WIDTH-1:0] address;  // BCD, units in the low nibble
        opcode_t                            insn;
    } fetch_t;

endpackage

// File: ipLine_defs.svh
`ifndef IPLINE_DEFS_SVH
`define IPLINE_DEFS_SVH

// one decimal digit is carried as a 4-bit BCD nibble
`define DIGIT_WIDTH 4

// instruction pointer digits, six in the chain
`define IP_DIGITS 6

// bracket nesting depth counter
`define LOOP_DIGITS 3

// opcode width
`define INSN_WIDTH 4

// program store, indexed by the low two pointer digits
`define ROM_DEPTH 100

// Clk cycles per dekatron step pulse
`define STEP_DIV 4

`endif

// File: program.hex
// test program, five opcodes per line, addresses ascending from 0
// 0 nop, 1 +, 2 -, 3 >, 4 <, 5 ., 6 ,, 7 [, 8 ], 9 halt
0 1 3 2 7
1 4 5 6 3
2 7 1 7 2
8 3 8 5 7
4 7 8 6 8
7 1 2 3 4
5 6 1 2 3
4 5 6 1 2
7 3 4 5 6
8 1 2 3 4
5 6 1 2 3
4 5 6 1 2
3 4 5 6 1
2 3 4 5 6
1 2 3 4 5
6 1 2 3 4
5 6 1 2 3
4 5 6 1 2
3 4 5 6 1
2 3 4 8 9

// File: project.f
+incdir+.
bfPkg.sv
HsClkGen.sv
DekatronCounter.sv
ProgramRom.sv
IpCounter.sv
IpLine.sv
InsnFetchTop.sv
tbInsnFetch.sv

// File: run.sh
#!/bin/sh
# build and run the instruction-fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tbInsnFetch -o VtbInsnFetch
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/VtbInsnFetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tbInsnFetch.sv
`timescale 1ns/1ps

module tbInsnFetch;

    import bfPkg::*;

    // one row of the step table
    typedef struct packed {
        logic        dataZero;
        logic [23:0] address;    // BCD
        opcode_t     insn;
    } stepEntry_t;

    localparam int numSteps   = 26;
    localparam int cycleLimit = numSteps * 600 + 100;

    logic   Clk;
    logic   Rst_n;
    logic   Request;
    logic   dataIsZeroed;
    logic   Ready;
    fetch_t Fetch;

    stepEntry_t  stepTable [numSteps];
    int          tableFill  = 0;
    logic [31:0] lfsrState;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    InsnFetchTop u_InsnFetchTop (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .Request      (Request),
        .dataIsZeroed (dataIsZeroed),
        .Ready        (Ready),
        .Fetch        (Fetch)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // run limit in clock cycles
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, no result after %0d cycles, errors so far %0d",
                     cycleCount, errorCount);
            $display("sim failed");
            $finish;
        end
    end

    // galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] nextState;
        if (state[0]) begin
            nextState = (state >> 1) ^ 32'h80200003;
        end else begin
            nextState = state >> 1;
        end
        return nextState;
    endfunction

    task automatic addStep(input logic dz, input logic [23:0] addr, input opcode_t op);
        stepTable[tableFill] = '{dataZero: dz, address: addr, insn: op};
        tableFill++;
    endtask

    // expected results worked out by hand from program.hex
    task automatic loadStepTable();
        addStep(1'b0, 24'h000001, OP_INC);
        addStep(1'b0, 24'h000002, OP_RIGHT);
        addStep(1'b0, 24'h000003, OP_DEC);
        addStep(1'b0, 24'h000004, OP_LOOP_OPEN);
        addStep(1'b0, 24'h000005, OP_INC);          // [ on nonzero data falls through
        addStep(1'b0, 24'h000006, OP_LEFT);
        addStep(1'b0, 24'h000007, OP_OUT);
        addStep(1'b0, 24'h000008, OP_IN);
        addStep(1'b0, 24'h000009, OP_RIGHT);
        addStep(1'b0, 24'h000010, OP_DEC);          // 9 to 10
        addStep(1'b0, 24'h000011, OP_LOOP_OPEN);
        addStep(1'b1, 24'h000018, OP_OUT);          // forward over the pair at 13..15
        addStep(1'b0, 24'h000019, OP_LOOP_OPEN);
        addStep(1'b0, 24'h000020, OP_LEFT);
        addStep(1'b0, 24'h000021, OP_LOOP_OPEN);
        addStep(1'b0, 24'h000022, OP_LOOP_CLOSE);
        addStep(1'b1, 24'h000023, OP_IN);           // ] on zero data falls through
        addStep(1'b0, 24'h000024, OP_LOOP_CLOSE);
        addStep(1'b0, 24'h000020, OP_LEFT);         // back to the [ at 19
        addStep(1'b0, 24'h000021, OP_LOOP_OPEN);
        addStep(1'b1, 24'h000023, OP_IN);
        addStep(1'b0, 24'h000024, OP_LOOP_CLOSE);
        addStep(1'b1, 24'h000025, OP_LOOP_OPEN);
        addStep(1'b1, 24'h000099, OP_HALT);         // long scan to the ] at 98
        addStep(1'b0, 24'h000100, OP_NOP);          // ROM index wraps to 0
        addStep(1'b0, 24'h000101, OP_INC);
    endtask

    // 0 to 3 idle cycles, two LFSR bits
    task automatic waitIdleGap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsrState = lfsrNext(lfsrState);
            gap = gap * 2 + int'(lfsrState[0]);
        end
        repeat (gap) @(posedge Clk);
    endtask

    task automatic checkFetch(input string label, input logic [23:0] expAddr,
                              input opcode_t expInsn);
        checkCount++;
        assert (Fetch.address === expAddr) else begin
            errorCount++;
            $display("[FAIL] %0t %s: address %06h, expected %06h",
                     $time, label, Fetch.address, expAddr);
        end
        checkCount++;
        assert (Fetch.insn === expInsn) else begin
            errorCount++;
            $display("[FAIL] %0t %s: opcode %0d, expected %0d",
                     $time, label, Fetch.insn, expInsn);
        end
    endtask

    task automatic runStep(input int idx);
        stepEntry_t entry;
        entry = stepTable[idx];
        @(posedge Clk);
        #1;
        dataIsZeroed = entry.dataZero;
        Request      = 1'b1;
        @(negedge Clk);
        checkCount++;
        assert (!Ready) else begin
            errorCount++;
            $display("[FAIL] %0t Ready rose while Request held, step %0d", $time, idx);
        end
        while (Ready) begin
            @(negedge Clk);
        end
        @(posedge Clk);
        #1;
        Request = 1'b0;
        // result is valid once Ready comes back
        @(negedge Clk);
        while (!Ready) begin
            @(negedge Clk);
        end
        checkFetch($sformatf("step %0d", idx), entry.address, entry.insn);
    endtask

    initial begin
        Rst_n        = 1'b0;
        Request      = 1'b0;
        dataIsZeroed = 1'b0;
        lfsrState    = 32'hb727;
        loadStepTable();
        repeat (5) @(posedge Clk);
        #1;
        Rst_n = 1'b1;
        @(negedge Clk);
        checkCount++;
        assert (Ready) else begin
            errorCount++;
            $display("[FAIL] %0t Ready low after reset", $time);
        end
        checkFetch("reset", 24'h000000, OP_NOP);

        for (int i = 0; i < numSteps; i++) begin
            waitIdleGap();
            runStep(i);
        end

        $display("checks %0d, errors %0d, cycles %0d", checkCount, errorCount, cycleCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
